//--- hw/obi_integrity_pkg.sv
// --------------------
// OBI response integrity package
// Widths, lane and payload types and the
// alert controller states shared by all blocks
// --------------------

package obi_integrity_pkg;

  // Fixed by the bus protocol
  localparam int WORD_W = 32;
  localparam int LANE_W = 8;

  // Four data byte lanes plus one status lane
  localparam int N_LANES = 5;
  localparam int STATUS_LANE = N_LANES - 1;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LANE_W-1:0] lane_t;

  // One checksum bit per lane
  typedef logic [N_LANES-1:0] rchk_t;

  // Response as it arrives from the memory
  typedef struct packed {
    word_t rdata;
    logic  err;
    rchk_t rchk;
  } resp_in_s;

  // One lane with its checksum bit
  typedef struct packed {
    lane_t value;
    logic  chk;
  } lane_s;

  // Response as it leaves toward the consumer
  typedef struct packed {
    word_t rdata;
    logic  err;
    logic  integrity_err;
  } resp_out_s;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_LANES,
    REQ,
    WAIT_ACK_LOW
  } ctrl_state_e;

endpackage

//--- hw/obi_resp_capture.sv
// --------------------
// Response capture
// Acknowledges the memory over a four-phase
// handshake, checks the req parity companion and
// splits the registered response into lanes
// --------------------

`timescale 1ns/1ps

module obi_resp_capture (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         in_req_i,
  input  logic                         in_reqpar_i,
  input  obi_integrity_pkg::resp_in_s  in_resp_i,
  input  logic                         resp_done_i,
  output logic                         in_ack_o,
  output logic                         in_ackpar_o,
  output obi_integrity_pkg::lane_s [obi_integrity_pkg::N_LANES-1:0] lane_o,
  output logic                         lane_valid_o,
  output logic                         parity_err_o
);

  logic in_ack_q;
  logic busy_q;
  logic lane_valid_q;
  logic parity_err_q;
  logic accept;

  obi_integrity_pkg::lane_s [obi_integrity_pkg::N_LANES-1:0] lane_q;

  // A new response is taken only once the previous one has left the output side
  assign accept = in_req_i && !in_ack_q && !busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      in_ack_q     <= 1'b0;
      busy_q       <= 1'b0;
      lane_valid_q <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      lane_valid_q <= accept;
      // The companion is the complement of req, so equal values mean a glitch
      parity_err_q <= (in_reqpar_i == in_req_i);

      if (accept) begin
        in_ack_q <= 1'b1;
      end else if (!in_req_i) begin
        in_ack_q <= 1'b0;
      end

      if (accept) begin
        busy_q <= 1'b1;
      end else if (resp_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Lane payload is loaded on acceptance and held while the response is in flight
  always_ff @(posedge clk_i) begin
    if (accept) begin
      for (int i = 0; i < obi_integrity_pkg::STATUS_LANE; i++) begin
        lane_q[i].value <=
          in_resp_i.rdata[i*obi_integrity_pkg::LANE_W +: obi_integrity_pkg::LANE_W];
        lane_q[i].chk   <= in_resp_i.rchk[i];
      end
      // Status lane carries err only, exokay is tied to zero
      lane_q[obi_integrity_pkg::STATUS_LANE].value <=
        {{(obi_integrity_pkg::LANE_W-1){1'b0}}, in_resp_i.err};
      lane_q[obi_integrity_pkg::STATUS_LANE].chk   <=
        in_resp_i.rchk[obi_integrity_pkg::STATUS_LANE];
    end
  end

  assign in_ack_o     = in_ack_q;
  assign in_ackpar_o  = ~in_ack_q;
  assign lane_o       = lane_q;
  assign lane_valid_o = lane_valid_q;
  assign parity_err_o = parity_err_q;

  // No second acknowledge before the controller has finished the previous response
  a_no_ack_while_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(in_ack_q) |-> !$past(busy_q)
  );

endmodule

//--- hw/obi_lane_check.sv
// --------------------
// Checksum lane checker
// Compares the XOR of one lane against its
// checksum bit and keeps a sticky fault flag
// --------------------

`timescale 1ns/1ps

module obi_lane_check (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  obi_integrity_pkg::lane_s lane_i,
  input  logic                     lane_valid_i,
  output logic                     mismatch_o,
  output logic                     res_valid_o,
  output logic                     fault_o
);

  logic bad;
  logic mismatch_q;
  logic res_valid_q;
  logic fault_q;

  assign bad = (^lane_i.value) != lane_i.chk;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mismatch_q  <= 1'b0;
      res_valid_q <= 1'b0;
      fault_q     <= 1'b0;
    end else begin
      res_valid_q <= lane_valid_i;
      if (lane_valid_i) begin
        // Held until the next response so the controller can read it late
        mismatch_q <= bad;
        // Fault is recorded whether or not checking is enabled
        if (bad) begin
          fault_q <= 1'b1;
        end
      end
    end
  end

  assign mismatch_o  = mismatch_q;
  assign res_valid_o = res_valid_q;
  assign fault_o     = fault_q;

  // One result per response, the input handshake spaces responses apart
  a_single_result: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    res_valid_q |=> !res_valid_q
  );

endmodule

//--- hw/obi_alert_ctrl.sv
// --------------------
// Alert controller
// Collects lane results and parity status, sets
// integrity_err on the forwarded response, drives
// the output handshake and the sticky major alert
// --------------------

`timescale 1ns/1ps

module obi_alert_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                integrity_en_i,
  input  logic                                parity_err_i,
  input  logic [obi_integrity_pkg::N_LANES-1:0] mismatch_i,
  input  logic [obi_integrity_pkg::N_LANES-1:0] res_valid_i,
  input  obi_integrity_pkg::word_t            rdata_i,
  input  logic                                err_i,
  input  logic                                out_ack_i,
  output logic                                out_req_o,
  output obi_integrity_pkg::resp_out_s        out_resp_o,
  output logic                                resp_done_o,
  output logic                                alert_major_o
);

  obi_integrity_pkg::ctrl_state_e state_q;
  obi_integrity_pkg::ctrl_state_e state_d;

  logic [obi_integrity_pkg::N_LANES-1:0] seen_q;
  logic [obi_integrity_pkg::N_LANES-1:0] seen_d;

  logic all_seen;
  logic launch;
  logic integrity_err;
  logic par_flag_q;
  logic out_req_q;
  logic resp_done_q;
  logic alert_q;

  obi_integrity_pkg::resp_out_s out_resp_q;

  // Lanes normally report together, a partial set waits in WAIT_LANES
  assign seen_d   = seen_q | res_valid_i;
  assign all_seen = &seen_d;

  // Parity errors always count, checksum mismatches only while enabled
  assign integrity_err = par_flag_q | parity_err_i | (integrity_en_i & (|mismatch_i));

  always_comb begin
    state_d = state_q;
    launch  = 1'b0;
    case (state_q)
      obi_integrity_pkg::IDLE: begin
        if (|res_valid_i) begin
          if (all_seen) begin
            launch  = 1'b1;
            state_d = obi_integrity_pkg::REQ;
          end else begin
            state_d = obi_integrity_pkg::WAIT_LANES;
          end
        end
      end
      obi_integrity_pkg::WAIT_LANES: begin
        if (all_seen) begin
          launch  = 1'b1;
          state_d = obi_integrity_pkg::REQ;
        end
      end
      obi_integrity_pkg::REQ: begin
        if (out_ack_i) begin
          state_d = obi_integrity_pkg::WAIT_ACK_LOW;
        end
      end
      obi_integrity_pkg::WAIT_ACK_LOW: begin
        if (!out_ack_i) begin
          state_d = obi_integrity_pkg::IDLE;
        end
      end
      default: state_d = obi_integrity_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= obi_integrity_pkg::IDLE;
      seen_q      <= '0;
      par_flag_q  <= 1'b0;
      out_req_q   <= 1'b0;
      resp_done_q <= 1'b0;
      alert_q     <= 1'b0;
    end else begin
      state_q <= state_d;

      if (launch) begin
        seen_q <= '0;
      end else begin
        seen_q <= seen_d;
      end

      // Glitches seen after a launch are charged to the next response
      if (launch) begin
        par_flag_q <= 1'b0;
      end else begin
        par_flag_q <= par_flag_q | parity_err_i;
      end

      if (launch) begin
        out_req_q <= 1'b1;
      end else if (state_q == obi_integrity_pkg::REQ && out_ack_i) begin
        out_req_q <= 1'b0;
      end

      resp_done_q <= (state_q == obi_integrity_pkg::WAIT_ACK_LOW) && !out_ack_i;

      alert_q <= alert_q | parity_err_i | (launch & integrity_err);
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch) begin
      out_resp_q.rdata         <= rdata_i;
      out_resp_q.err           <= err_i;
      out_resp_q.integrity_err <= integrity_err;
    end
  end

  assign out_req_o     = out_req_q;
  assign out_resp_o    = out_resp_q;
  assign resp_done_o   = resp_done_q;
  assign alert_major_o = alert_q;

  // Only reset clears the major alert
  a_alert_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    alert_q |=> alert_q
  );

  // Payload must not move under a pending request
  a_resp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_req_q |=> !out_req_q || $stable(out_resp_q)
  );

endmodule

//--- hw/obi_integrity_top.sv
// --------------------
// OBI response integrity checker
// Capture stage, one checker per checksum lane
// and the alert controller
// --------------------

`timescale 1ns/1ps

module obi_integrity_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         integrity_en_i,
  input  logic                         in_req_i,
  input  logic                         in_reqpar_i,
  input  obi_integrity_pkg::resp_in_s  in_resp_i,
  input  logic                         out_ack_i,
  output logic                         in_ack_o,
  output logic                         in_ackpar_o,
  output logic                         out_req_o,
  output obi_integrity_pkg::resp_out_s out_resp_o,
  output logic                         alert_major_o,
  output obi_integrity_pkg::rchk_t     lane_fault_o
);

  obi_integrity_pkg::lane_s [obi_integrity_pkg::N_LANES-1:0] lane;

  logic                                  lane_valid;
  logic                                  parity_err;
  logic                                  resp_done;
  logic [obi_integrity_pkg::N_LANES-1:0] mismatch;
  logic [obi_integrity_pkg::N_LANES-1:0] res_valid;
  obi_integrity_pkg::word_t              rdata;
  logic                                  err;

  obi_resp_capture u_capture (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_req_i     (in_req_i),
    .in_reqpar_i  (in_reqpar_i),
    .in_resp_i    (in_resp_i),
    .resp_done_i  (resp_done),
    .in_ack_o     (in_ack_o),
    .in_ackpar_o  (in_ackpar_o),
    .lane_o       (lane),
    .lane_valid_o (lane_valid),
    .parity_err_o (parity_err)
  );

  for (genvar i = 0; i < obi_integrity_pkg::N_LANES; i++) begin : g_lane
    obi_lane_check u_check (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .lane_i       (lane[i]),
      .lane_valid_i (lane_valid),
      .mismatch_o   (mismatch[i]),
      .res_valid_o  (res_valid[i]),
      .fault_o      (lane_fault_o[i])
    );
  end

  // Forwarded data comes from the registered lanes, not the live bus
  for (genvar i = 0; i < obi_integrity_pkg::STATUS_LANE; i++) begin : g_rdata
    assign rdata[i*obi_integrity_pkg::LANE_W +: obi_integrity_pkg::LANE_W] = lane[i].value;
  end

  assign err = lane[obi_integrity_pkg::STATUS_LANE].value[0];

  obi_alert_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .integrity_en_i (integrity_en_i),
    .parity_err_i   (parity_err),
    .mismatch_i     (mismatch),
    .res_valid_i    (res_valid),
    .rdata_i        (rdata),
    .err_i          (err),
    .out_ack_i      (out_ack_i),
    .out_req_o      (out_req_o),
    .out_resp_o     (out_resp_o),
    .resp_done_o    (resp_done),
    .alert_major_o  (alert_major_o)
  );

endmodule

//--- bench/tb_obi_integrity.sv
// --------------------
// Testbench for the OBI response integrity checker
// Random responses, checksum flips, req parity glitches
// and consumer back-pressure against a reference model
// --------------------

`timescale 1ns/1ps

module tb_obi_integrity;

  localparam int TIMEOUT = 60;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         integrity_en_i;
  logic                         in_req_i;
  logic                         in_reqpar_i;
  logic                         out_ack_i;
  obi_integrity_pkg::resp_in_s  in_resp_i;
  logic                         in_ack_o;
  logic                         in_ackpar_o;
  logic                         out_req_o;
  logic                         alert_major_o;
  obi_integrity_pkg::resp_out_s out_resp_o;
  obi_integrity_pkg::rchk_t     lane_fault_o;

  logic [31:0]              rng_state = 32'h449e;
  int                       cycle = 0;
  int                       errors = 0;
  int                       checks = 0;
  int                       accepted = 0;
  int                       completed = 0;
  bit                       aborted = 1'b0;
  logic                     prev_ack = 1'b0;
  logic                     exp_alert;
  obi_integrity_pkg::rchk_t exp_fault;

  // Expected results in response order, filled when a request is raised
  obi_integrity_pkg::resp_out_s exp_resp_q[$];
  logic                         exp_alert_q[$];
  obi_integrity_pkg::rchk_t     exp_fault_q[$];
  int                           ack_cycle_q[$];
  int                           delay_q[$];

  obi_integrity_top dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .integrity_en_i (integrity_en_i),
    .in_req_i       (in_req_i),
    .in_reqpar_i    (in_reqpar_i),
    .in_resp_i      (in_resp_i),
    .out_ack_i      (out_ack_i),
    .in_ack_o       (in_ack_o),
    .in_ackpar_o    (in_ackpar_o),
    .out_req_o      (out_req_o),
    .out_resp_o     (out_resp_o),
    .alert_major_o  (alert_major_o),
    .lane_fault_o   (lane_fault_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Reference checksum: XOR of each data byte, err itself on the status lane
  function automatic obi_integrity_pkg::rchk_t model_rchk(obi_integrity_pkg::word_t d, logic e);
    obi_integrity_pkg::rchk_t c;
    for (int i = 0; i < 4; i++) begin
      c[i] = ^d[i*8 +: 8];
    end
    c[4] = e;
    return c;
  endfunction

  task automatic check_resp(obi_integrity_pkg::resp_out_s got, obi_integrity_pkg::resp_out_s exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display({"CHECK FAILED t=%0t out_resp_o got rdata=%h err=%b integrity_err=%b",
                " expected rdata=%h err=%b integrity_err=%b"},
               $time, got.rdata, got.err, got.integrity_err,
               exp.rdata, exp.err, exp.integrity_err);
    end
  endtask

  task automatic check_alert(logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t alert_major_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_lane_fault(obi_integrity_pkg::rchk_t got, obi_integrity_pkg::rchk_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t lane_fault_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_delay(string name, int got, int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %0d cycles expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(string what);
    errors++;
    aborted = 1'b1;
    $display("t=%0t run stopped: %s", $time, what);
  endtask

  // Acknowledge parity, and no new acceptance while a response is still in flight
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      prev_ack = 1'b0;
    end else begin
      check_flag("in_ackpar_o", in_ackpar_o, ~in_ack_o);
      if (in_ack_o && !prev_ack) begin
        if (accepted != completed) begin
          errors++;
          $display("t=%0t in_ack_o rose before the previous output handshake ended", $time);
        end
        accepted++;
        ack_cycle_q.push_back(cycle);
      end
      prev_ack = in_ack_o;
    end
  end

  task automatic send_n(int n, logic en, bit use_flip, bit use_glitch);
    logic [31:0]                  rnd;
    obi_integrity_pkg::resp_in_s  r;
    obi_integrity_pkg::resp_out_s e;
    obi_integrity_pkg::rchk_t     flip;
    logic                         glitch;
    logic                         alert_before;
    int                           w;
    for (int k = 0; k < n && !aborted; k++) begin
      r.rdata = next_rand();
      rnd = next_rand();
      r.err = rnd[0];
      flip = (use_flip && rnd[9:8] != 2'b00) ? rnd[4:0] : '0;
      glitch = use_glitch && (k == 0 || rnd[12:11] == 2'b00);
      r.rchk = model_rchk(r.rdata, r.err) ^ flip;
      e.rdata = r.rdata;
      e.err = r.err;
      e.integrity_err = glitch | (en & (|flip));
      alert_before = exp_alert;
      exp_alert = exp_alert | e.integrity_err;
      exp_fault = exp_fault | flip;
      exp_resp_q.push_back(e);
      exp_alert_q.push_back(exp_alert);
      exp_fault_q.push_back(exp_fault);
      in_resp_i = r;
      in_req_i = 1'b1;
      // Equal req and companion for one cycle is a parity glitch
      in_reqpar_i = glitch;
      if (glitch) begin
        @(negedge clk_i);
        in_reqpar_i = 1'b0;
        check_alert(alert_major_o, alert_before);
        @(negedge clk_i);
        check_alert(alert_major_o, 1'b1);
      end
      w = 0;
      while (!in_ack_o && w < TIMEOUT) begin
        @(negedge clk_i);
        w++;
      end
      if (!in_ack_o) begin
        abort_run("in_ack_o did not rise");
        return;
      end
      in_req_i = 1'b0;
      in_reqpar_i = 1'b1;
      w = 0;
      while (in_ack_o && w < TIMEOUT) begin
        @(negedge clk_i);
        w++;
      end
      if (in_ack_o) begin
        abort_run("in_ack_o did not fall");
        return;
      end
      repeat (int'(rnd[17:16])) @(negedge clk_i);
    end
  endtask

  task automatic consume_n(int n);
    int w;
    for (int k = 0; k < n && !aborted; k++) begin
      w = 0;
      while (!out_req_o && w < TIMEOUT && !aborted) begin
        @(negedge clk_i);
        w++;
      end
      if (!out_req_o || ack_cycle_q.size() == 0 || exp_resp_q.size() == 0) begin
        abort_run("no output request for an accepted response");
        return;
      end
      check_delay("out_req_o after in_ack_o", cycle - ack_cycle_q.pop_front(), 2);
      check_resp(out_resp_o, exp_resp_q.pop_front());
      check_alert(alert_major_o, exp_alert_q.pop_front());
      check_lane_fault(lane_fault_o, exp_fault_q.pop_front());
      repeat (delay_q.pop_front()) @(negedge clk_i);
      out_ack_i = 1'b1;
      w = 0;
      while (out_req_o && w < TIMEOUT) begin
        @(negedge clk_i);
        w++;
      end
      if (out_req_o) begin
        abort_run("out_req_o did not fall after out_ack_i");
        return;
      end
      repeat (delay_q.pop_front()) @(negedge clk_i);
      out_ack_i = 1'b0;
      completed++;
    end
  endtask

  task automatic run_test(string name, int n, logic en, bit use_flip, bit use_glitch);
    int          start;
    logic [31:0] rnd;
    if (aborted) return;
    start = errors;
    // Consumer delays are drawn up front so the two processes never share the generator
    for (int k = 0; k < 2 * n; k++) begin
      rnd = next_rand();
      delay_q.push_back(int'(rnd[1:0]));
    end
    @(negedge clk_i);
    integrity_en_i = en;
    fork
      send_n(n, en, use_flip, use_glitch);
      consume_n(n);
    join
    repeat (4) @(negedge clk_i);
    check_flag("out_req_o", out_req_o, 1'b0);
    if (exp_resp_q.size() != 0 || ack_cycle_q.size() != 0) begin
      errors++;
      $display("t=%0t responses were lost or duplicated in test %s", $time, name);
    end
    $display("test %s: %0d transfers, %0d errors", name, n, errors - start);
  endtask

  task automatic reset_test(string name);
    int start;
    start = errors;
    @(negedge clk_i);
    rst_ni = 1'b0;
    in_req_i = 1'b0;
    in_reqpar_i = 1'b1;
    out_ack_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    exp_alert = 1'b0;
    exp_fault = '0;
    accepted = 0;
    completed = 0;
    exp_resp_q.delete();
    exp_alert_q.delete();
    exp_fault_q.delete();
    ack_cycle_q.delete();
    delay_q.delete();
    check_flag("in_ack_o", in_ack_o, 1'b0);
    check_flag("in_ackpar_o", in_ackpar_o, 1'b1);
    check_flag("out_req_o", out_req_o, 1'b0);
    check_alert(alert_major_o, 1'b0);
    check_lane_fault(lane_fault_o, '0);
    $display("test %s: %0d errors", name, errors - start);
  endtask

  initial begin
    logic [31:0] rnd;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    integrity_en_i = 1'b1;
    in_req_i = 1'b0;
    in_reqpar_i = 1'b1;
    out_ack_i = 1'b0;
    in_resp_i = '0;
    reset_test("reset_start");
    run_test("clean_enabled", 24, 1'b1, 1'b0, 1'b0);
    run_test("flip_disabled", 24, 1'b0, 1'b1, 1'b0);
    reset_test("reset_after_faults");
    run_test("flip_enabled", 24, 1'b1, 1'b1, 1'b0);
    reset_test("reset_after_alert");
    run_test("parity_disabled", 16, 1'b0, 1'b0, 1'b1);
    // The enabled case starts from a cleared alert so the parity path is seen to set it
    reset_test("reset_between_parity");
    run_test("parity_enabled", 16, 1'b1, 1'b0, 1'b1);
    reset_test("reset_after_parity");
    rnd = next_rand();
    run_test("random_mix", 40, rnd[0], 1'b1, 1'b1);
    reset_test("reset_end");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !aborted) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hw/obi_integrity_pkg.sv
hw/obi_resp_capture.sv
hw/obi_lane_check.sv
hw/obi_alert_ctrl.sv
hw/obi_integrity_top.sv
bench/tb_obi_integrity.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f compile.f --top-module tb_obi_integrity -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || echo "build or run of the simulation did not complete"
grep -qsx "sim passed" sim.log && exit 0 || exit 1
